/* axi_delay_macros.svh */
// widths and LFSR seeds for the AXI delayer, include wherever a width or seed is needed
`ifndef AXI_DELAY_MACROS_SVH
`define AXI_DELAY_MACROS_SVH

// AXI field widths
`define AXI_ID_W    4
`define AXI_ADDR_W  32
`define AXI_DATA_W  32
`define AXI_LEN_W   8

// delay value width, max wait is 2**DELAY_W - 1 cycles
`define DELAY_W     4

// base LFSR seed, must stay nonzero
// each channel stage adds its own offset
`define LFSR_SEED_BASE 16'hACE1

`endif

/* axi_delay_pkg.sv */
// shared enum types for the AXI delayer, imported by the RTL and the testbench
package axi_delay_pkg;

  // where a stage gets its delay from
  typedef enum logic {
    DELAY_FIXED  = 1'b0,
    DELAY_RANDOM = 1'b1
  } delay_mode_e;

  // channel stage FSM
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_WAIT    = 2'd1,
    ST_PRESENT = 2'd2
  } stage_state_e;

  // AXI B/R response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

/* axi_delayer.sv */
// AXI delayer top, put between a master and memory to delay each of the five channels
`include "axi_delay_macros.svh"

module axi_delayer
  import axi_delay_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_i,
  input  delay_mode_e            delay_mode_i,
  input  logic [`DELAY_W-1:0]    fixed_delay_i,

  // slave side, faces the master
  input  logic                   aw_valid_i,
  input  logic [`AXI_ID_W-1:0]   aw_id_i,
  input  logic [`AXI_ADDR_W-1:0] aw_addr_i,
  input  logic [`AXI_LEN_W-1:0]  aw_len_i,
  output logic                   aw_ready_o,
  input  logic                   w_valid_i,
  input  logic [`AXI_DATA_W-1:0] w_data_i,
  input  logic [`AXI_DATA_W/8-1:0] w_strb_i,
  input  logic                   w_last_i,
  output logic                   w_ready_o,
  input  logic                   ar_valid_i,
  input  logic [`AXI_ID_W-1:0]   ar_id_i,
  input  logic [`AXI_ADDR_W-1:0] ar_addr_i,
  input  logic [`AXI_LEN_W-1:0]  ar_len_i,
  output logic                   ar_ready_o,
  output logic                   b_valid_o,
  output logic [`AXI_ID_W-1:0]   b_id_o,
  output resp_e                  b_resp_o,
  input  logic                   b_ready_i,
  output logic                   r_valid_o,
  output logic [`AXI_ID_W-1:0]   r_id_o,
  output logic [`AXI_DATA_W-1:0] r_data_o,
  output resp_e                  r_resp_o,
  output logic                   r_last_o,
  input  logic                   r_ready_i,

  // master side, faces memory
  output logic                   m_aw_valid_o,
  output logic [`AXI_ID_W-1:0]   m_aw_id_o,
  output logic [`AXI_ADDR_W-1:0] m_aw_addr_o,
  output logic [`AXI_LEN_W-1:0]  m_aw_len_o,
  input  logic                   m_aw_ready_i,
  output logic                   m_w_valid_o,
  output logic [`AXI_DATA_W-1:0] m_w_data_o,
  output logic [`AXI_DATA_W/8-1:0] m_w_strb_o,
  output logic                   m_w_last_o,
  input  logic                   m_w_ready_i,
  output logic                   m_ar_valid_o,
  output logic [`AXI_ID_W-1:0]   m_ar_id_o,
  output logic [`AXI_ADDR_W-1:0] m_ar_addr_o,
  output logic [`AXI_LEN_W-1:0]  m_ar_len_o,
  input  logic                   m_ar_ready_i,
  input  logic                   m_b_valid_i,
  input  logic [`AXI_ID_W-1:0]   m_b_id_i,
  input  resp_e                  m_b_resp_i,
  output logic                   m_b_ready_o,
  input  logic                   m_r_valid_i,
  input  logic [`AXI_ID_W-1:0]   m_r_id_i,
  input  logic [`AXI_DATA_W-1:0] m_r_data_i,
  input  resp_e                  m_r_resp_i,
  input  logic                   m_r_last_i,
  output logic                   m_r_ready_o
);

  // packed payload widths per channel
  localparam int AX_W = `AXI_ID_W + `AXI_ADDR_W + `AXI_LEN_W;
  localparam int W_W  = `AXI_DATA_W + `AXI_DATA_W / 8 + 1;
  localparam int B_W  = `AXI_ID_W + 2;
  localparam int R_W  = `AXI_ID_W + `AXI_DATA_W + 2 + 1;

  logic [AX_W-1:0] aw_pl;
  logic [W_W-1:0]  w_pl;
  logic [B_W-1:0]  b_pl;
  logic [AX_W-1:0] ar_pl;
  logic [R_W-1:0]  r_pl;

  // forward channels, slave port upstream
  chan_delay #(.WIDTH(AX_W), .SEED(`LFSR_SEED_BASE + 16'h0011)) u_aw (
    .clk (clk), .reset_i (reset_i),
    .delay_mode_i (delay_mode_i), .fixed_delay_i (fixed_delay_i),
    .valid_i (aw_valid_i), .payload_i ({aw_id_i, aw_addr_i, aw_len_i}), .ready_o (aw_ready_o),
    .valid_o (m_aw_valid_o), .payload_o (aw_pl), .ready_i (m_aw_ready_i)
  );

  chan_delay #(.WIDTH(W_W), .SEED(`LFSR_SEED_BASE + 16'h0230)) u_w (
    .clk (clk), .reset_i (reset_i),
    .delay_mode_i (delay_mode_i), .fixed_delay_i (fixed_delay_i),
    .valid_i (w_valid_i), .payload_i ({w_data_i, w_strb_i, w_last_i}), .ready_o (w_ready_o),
    .valid_o (m_w_valid_o), .payload_o (w_pl), .ready_i (m_w_ready_i)
  );

  chan_delay #(.WIDTH(AX_W), .SEED(`LFSR_SEED_BASE + 16'h4500)) u_ar (
    .clk (clk), .reset_i (reset_i),
    .delay_mode_i (delay_mode_i), .fixed_delay_i (fixed_delay_i),
    .valid_i (ar_valid_i), .payload_i ({ar_id_i, ar_addr_i, ar_len_i}), .ready_o (ar_ready_o),
    .valid_o (m_ar_valid_o), .payload_o (ar_pl), .ready_i (m_ar_ready_i)
  );

  // response channels run the other way
  chan_delay #(.WIDTH(B_W), .SEED(`LFSR_SEED_BASE + 16'h0607)) u_b (
    .clk (clk), .reset_i (reset_i),
    .delay_mode_i (delay_mode_i), .fixed_delay_i (fixed_delay_i),
    .valid_i (m_b_valid_i), .payload_i ({m_b_id_i, m_b_resp_i}), .ready_o (m_b_ready_o),
    .valid_o (b_valid_o), .payload_o (b_pl), .ready_i (b_ready_i)
  );

  chan_delay #(.WIDTH(R_W), .SEED(`LFSR_SEED_BASE + 16'h7080)) u_r (
    .clk (clk), .reset_i (reset_i),
    .delay_mode_i (delay_mode_i), .fixed_delay_i (fixed_delay_i),
    .valid_i (m_r_valid_i),
    .payload_i ({m_r_id_i, m_r_data_i, m_r_resp_i, m_r_last_i}),
    .ready_o (m_r_ready_o),
    .valid_o (r_valid_o), .payload_o (r_pl), .ready_i (r_ready_i)
  );

  // unpack in the same field order as packed
  assign {m_aw_id_o, m_aw_addr_o, m_aw_len_o} = aw_pl;
  assign {m_w_data_o, m_w_strb_o, m_w_last_o} = w_pl;
  assign {m_ar_id_o, m_ar_addr_o, m_ar_len_o} = ar_pl;

  assign b_id_o   = b_pl[B_W-1:2];
  assign b_resp_o = resp_e'(b_pl[1:0]);

  assign r_id_o   = r_pl[R_W-1:R_W-`AXI_ID_W];
  assign r_data_o = r_pl[`AXI_DATA_W+2:3];
  assign r_resp_o = resp_e'(r_pl[2:1]);
  assign r_last_o = r_pl[0];

endmodule

/* chan_delay.sv */
// one-beat AXI channel stage that holds a beat for a fixed or random number of cycles
`include "axi_delay_macros.svh"

module chan_delay
  import axi_delay_pkg::*;
#(
  parameter int          WIDTH = 8,
  parameter logic [15:0] SEED  = `LFSR_SEED_BASE
) (
  input  logic                clk,
  input  logic                reset_i,

  // delay control
  input  delay_mode_e         delay_mode_i,
  input  logic [`DELAY_W-1:0] fixed_delay_i,

  // upstream side
  input  logic                valid_i,
  input  logic [WIDTH-1:0]    payload_i,
  output logic                ready_o,

  // downstream side
  output logic                valid_o,
  output logic [WIDTH-1:0]    payload_o,
  input  logic                ready_i
);

  stage_state_e        state_q;
  logic [`DELAY_W-1:0] cnt_q;
  logic [`DELAY_W-1:0] rand_delay;
  logic [`DELAY_W-1:0] delay_d;
  logic [WIDTH-1:0]    payload_q;
  logic                accept;

  stall_lfsr #(
    .SEED (SEED)
  ) u_lfsr (
    .clk     (clk),
    .reset_i (reset_i),
    .rand_o  (rand_delay)
  );

  // delay source picked at the capture edge
  assign delay_d = (delay_mode_i == DELAY_RANDOM) ? rand_delay : fixed_delay_i;

  assign accept = (state_q == ST_IDLE) && valid_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (valid_i) begin
            state_q <= ST_WAIT;
            cnt_q   <= delay_d;
          end
        end
        ST_WAIT: begin
          // zero count means present on the next edge, so latency is 1+D
          if (cnt_q == '0) begin
            state_q <= ST_PRESENT;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        ST_PRESENT: begin
          // hold until downstream takes the beat
          if (ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (accept) begin
      payload_q <= payload_i;
    end
  end

  assign ready_o   = (state_q == ST_IDLE);
  assign valid_o   = (state_q == ST_PRESENT);
  assign payload_o = payload_q;

endmodule

/* files.f */
+incdir+.
axi_delay_pkg.sv
stall_lfsr.sv
chan_delay.sv
axi_delayer.sv
tb_axi_delayer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the AXI delayer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_axi_delayer \
  -o sim_axi_delayer > build.log 2>&1 \
  && ./obj_dir/sim_axi_delayer > sim.log 2>&1 \
  || { echo "build or simulation run failed"; exit 1; }
grep -q "TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

/* stall_lfsr.sv */
// free-running pseudo-random source, one instance per channel stage for random delays
`include "axi_delay_macros.svh"

module stall_lfsr #(
  parameter logic [15:0] SEED = `LFSR_SEED_BASE
) (
  input  logic                clk,
  input  logic                reset_i,
  output logic [`DELAY_W-1:0] rand_o
);

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] TAPS = 16'hB400;

  logic [15:0] lfsr_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      lfsr_q <= SEED;
    end else if (lfsr_q[0]) begin
      lfsr_q <= {1'b0, lfsr_q[15:1]} ^ TAPS;
    end else begin
      lfsr_q <= {1'b0, lfsr_q[15:1]};
    end
  end

  // low bits are enough for a short delay
  assign rand_o = lfsr_q[`DELAY_W-1:0];

endmodule

/* tb_axi_delayer.sv */
// directed testbench for the AXI delayer, compiled from files.f and run by run_sim.sh
`include "axi_delay_macros.svh"

module tb_axi_delayer
  import axi_delay_pkg::*;
();

  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_AR = 2;
  localparam int CH_B  = 3;
  localparam int CH_R  = 4;
  localparam int TIMEOUT = 40;
  // packed beat widths used by the testbench
  localparam int AX_W = `AXI_ID_W + `AXI_ADDR_W + `AXI_LEN_W;
  localparam int W_W  = `AXI_DATA_W + `AXI_DATA_W / 8 + 1;

  logic clk;
  logic reset_i;
  delay_mode_e delay_mode_i;
  logic [`DELAY_W-1:0] fixed_delay_i;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_last_i, w_ready_o, ar_valid_i, ar_ready_o;
  logic [`AXI_ID_W-1:0] aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic [`AXI_ADDR_W-1:0] aw_addr_i, ar_addr_i;
  logic [`AXI_LEN_W-1:0] aw_len_i, ar_len_i;
  logic [`AXI_DATA_W-1:0] w_data_i, r_data_o;
  logic [`AXI_DATA_W/8-1:0] w_strb_i;
  logic b_valid_o, b_ready_i, r_valid_o, r_last_o, r_ready_i;
  resp_e b_resp_o, r_resp_o;
  logic m_aw_valid_o, m_aw_ready_i, m_w_valid_o, m_w_last_o, m_w_ready_i;
  logic m_ar_valid_o, m_ar_ready_i;
  logic [`AXI_ID_W-1:0] m_aw_id_o, m_ar_id_o, m_b_id_i, m_r_id_i;
  logic [`AXI_ADDR_W-1:0] m_aw_addr_o, m_ar_addr_o;
  logic [`AXI_LEN_W-1:0] m_aw_len_o, m_ar_len_o;
  logic [`AXI_DATA_W-1:0] m_w_data_o, m_r_data_i;
  logic [`AXI_DATA_W/8-1:0] m_w_strb_o;
  logic m_b_valid_i, m_b_ready_o, m_r_valid_i, m_r_last_i, m_r_ready_o;
  resp_e m_b_resp_i, m_r_resp_i;

  int errors;
  int checks;
  int tests_run;
  int tests_bad;

  axi_delayer UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic string chan_name(int ch);
    case (ch)
      CH_AW: return "aw";
      CH_W: return "w";
      CH_AR: return "ar";
      CH_B: return "b";
      default: return "r";
    endcase
  endfunction

  // name of a port on the output side of a stage
  function automatic string out_name(int ch, string field);
    string base;
    base = {chan_name(ch), field};
    if (ch < CH_B) begin
      base = {"m_", base};
    end
    return base;
  endfunction

  function automatic string in_name(int ch, string field);
    string base;
    base = {chan_name(ch), field};
    if (ch >= CH_B) begin
      base = {"m_", base};
    end
    return base;
  endfunction

  function automatic logic [63:0] rand_payload(int ch);
    logic [63:0] r;
    int w;
    r = {$urandom, $urandom};
    case (ch)
      CH_AW, CH_AR: w = AX_W;
      CH_W: w = W_W;
      CH_B: w = `AXI_ID_W + 2;
      default: w = `AXI_ID_W + `AXI_DATA_W + 3;
    endcase
    return r & ((64'd1 << w) - 64'd1);
  endfunction

  task automatic drive_input(input int ch, input logic valid, input logic [63:0] pl);
    case (ch)
      CH_AW: begin
        aw_valid_i <= valid;
        {aw_id_i, aw_addr_i, aw_len_i} <= pl[AX_W-1:0];
      end
      CH_W: begin
        w_valid_i <= valid;
        {w_data_i, w_strb_i, w_last_i} <= pl[W_W-1:0];
      end
      CH_AR: begin
        ar_valid_i <= valid;
        {ar_id_i, ar_addr_i, ar_len_i} <= pl[AX_W-1:0];
      end
      CH_B: begin
        m_b_valid_i <= valid;
        m_b_id_i <= pl[5:2];
        m_b_resp_i <= resp_e'(pl[1:0]);
      end
      default: begin
        m_r_valid_i <= valid;
        m_r_id_i <= pl[38:35];
        m_r_data_i <= pl[34:3];
        m_r_resp_i <= resp_e'(pl[2:1]);
        m_r_last_i <= pl[0];
      end
    endcase
  endtask

  task automatic set_out_ready(input int ch, input logic val);
    case (ch)
      CH_AW: m_aw_ready_i <= val;
      CH_W: m_w_ready_i <= val;
      CH_AR: m_ar_ready_i <= val;
      CH_B: b_ready_i <= val;
      default: r_ready_i <= val;
    endcase
  endtask

  function automatic logic input_ready(int ch);
    case (ch)
      CH_AW: return aw_ready_o;
      CH_W: return w_ready_o;
      CH_AR: return ar_ready_o;
      CH_B: return m_b_ready_o;
      default: return m_r_ready_o;
    endcase
  endfunction

  function automatic logic output_valid(int ch);
    case (ch)
      CH_AW: return m_aw_valid_o;
      CH_W: return m_w_valid_o;
      CH_AR: return m_ar_valid_o;
      CH_B: return b_valid_o;
      default: return r_valid_o;
    endcase
  endfunction

  function automatic logic [63:0] output_payload(int ch);
    case (ch)
      CH_AW: return 64'({m_aw_id_o, m_aw_addr_o, m_aw_len_o});
      CH_W: return 64'({m_w_data_o, m_w_strb_o, m_w_last_o});
      CH_AR: return 64'({m_ar_id_o, m_ar_addr_o, m_ar_len_o});
      CH_B: return 64'({b_id_o, b_resp_o});
      default: return 64'({r_id_o, r_data_o, r_resp_o, r_last_o});
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // returns just after the accept edge with valid already dropped
  task automatic send_beat(input int ch, input logic [63:0] pl);
    int waited;
    @(posedge clk);
    drive_input(ch, 1'b1, pl);
    waited = 0;
    @(negedge clk);
    while (!input_ready(ch) && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    assert (waited < TIMEOUT) else begin
      $display("%s stage never became ready for a new beat", chan_name(ch));
      errors++;
    end
    @(posedge clk);
    drive_input(ch, 1'b0, pl);
  endtask

  // counts edges after the accept edge until valid shows on the output side
  task automatic await_output(input int ch, output int lat);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (!output_valid(ch) && lat < TIMEOUT);
    assert (output_valid(ch)) else begin
      $display("%s beat never came out of the delayer", chan_name(ch));
      errors++;
    end
  endtask

  task automatic beat_in_bounds(input int ch, output int lat);
    logic [63:0] pl;
    pl = rand_payload(ch);
    send_beat(ch, pl);
    await_output(ch, lat);
    checks++;
    assert (lat >= 1 && lat <= 16) else begin
      $display("Error: %s latency 0x%0h outside 0x1..0x10", out_name(ch, "_valid_o"), lat);
      errors++;
    end
    check_value(out_name(ch, "_payload"), output_payload(ch), pl);
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    if (errors != start) begin
      tests_bad++;
    end
    $display("%-16s %s, %0d errors", name, (errors == start) ? "ok" : "with errors",
             errors - start);
  endtask

  task automatic reset_values();
    int start;
    start = errors;
    @(negedge clk);
    for (int ch = CH_AW; ch <= CH_R; ch++) begin
      check_value(out_name(ch, "_valid_o"), output_valid(ch), 1'b0);
      check_value(in_name(ch, "_ready_o"), input_ready(ch), 1'b1);
    end
    finish_test("reset values", start);
  endtask

  task automatic fixed_latency();
    int start;
    int lat;
    logic [`DELAY_W-1:0] d;
    logic [63:0] pl;
    start = errors;
    for (int i = 0; i < 3; i++) begin
      d = (i == 0) ? 4'd0 : (i == 1) ? 4'd3 : 4'd15;
      @(posedge clk);
      delay_mode_i <= DELAY_FIXED;
      fixed_delay_i <= d;
      for (int ch = CH_AW; ch <= CH_AR; ch++) begin
        pl = rand_payload(ch);
        send_beat(ch, pl);
        await_output(ch, lat);
        check_value(out_name(ch, "_valid_o latency"), lat, 1 + d);
        check_value(out_name(ch, "_payload"), output_payload(ch), pl);
      end
    end
    finish_test("fixed latency", start);
  endtask

  task automatic random_latency();
    int start;
    int lat;
    int lat_min;
    int lat_max;
    start = errors;
    @(posedge clk);
    delay_mode_i <= DELAY_RANDOM;
    for (int ch = CH_AW; ch <= CH_AR; ch++) begin
      lat_min = TIMEOUT;
      lat_max = 0;
      repeat (50) begin
        beat_in_bounds(ch, lat);
        if (lat < lat_min) begin
          lat_min = lat;
        end
        if (lat > lat_max) begin
          lat_max = lat;
        end
      end
      // a fixed delay would give the same latency every time
      checks++;
      assert (lat_max > lat_min) else begin
        $display("%s latency never varied in random mode", chan_name(ch));
        errors++;
      end
    end
    finish_test("random latency", start);
  endtask

  task automatic back_pressure();
    int start;
    int lat;
    int held;
    logic [63:0] pl;
    start = errors;
    repeat (3) begin
      @(posedge clk);
      m_aw_ready_i <= 1'b0;
      pl = rand_payload(CH_AW);
      send_beat(CH_AW, pl);
      await_output(CH_AW, lat);
      held = $urandom_range(10, 1);
      repeat (held) begin
        @(posedge clk);
        @(negedge clk);
        check_value("m_aw_valid_o", m_aw_valid_o, 1'b1);
        check_value("m_aw_payload", output_payload(CH_AW), pl);
        check_value("aw_ready_o", aw_ready_o, 1'b0);
      end
      @(posedge clk);
      m_aw_ready_i <= 1'b1;
      @(negedge clk);
      check_value("m_aw_valid_o", m_aw_valid_o, 1'b1);
      // transfer edge
      @(posedge clk);
      @(negedge clk);
      check_value("m_aw_valid_o", m_aw_valid_o, 1'b0);
      check_value("aw_ready_o", aw_ready_o, 1'b1);
    end
    finish_test("back pressure", start);
  endtask

  task automatic response_path();
    int start;
    int lat;
    start = errors;
    for (int ch = CH_B; ch <= CH_R; ch++) begin
      repeat (20) beat_in_bounds(ch, lat);
    end
    finish_test("responses", start);
  endtask

  initial begin
    void'($urandom(38432));
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_bad = 0;
    reset_i = 1'b1;
    delay_mode_i = DELAY_FIXED;
    fixed_delay_i = '0;
    for (int ch = CH_AW; ch <= CH_R; ch++) begin
      drive_input(ch, 1'b0, 64'd0);
      set_out_ready(ch, 1'b1);
    end
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    reset_values();
    fixed_latency();
    random_latency();
    back_pressure();
    response_path();
    $display("tests run %0d, failing tests %0d, checks %0d, errors %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
